// File: project.f
+incdir+dv
hw/ctrlPkg.sv
hw/stageIfs.sv
hw/condUnit.sv
hw/instrDecoder.sv
hw/executeCtrl.sv
hw/writebackCtrl.sv
hw/armController.sv
dv/armControllerTb.sv

// File: Makefile
# Verilator build for the pipeline controller testbench

VERILATOR ?= verilator
TOP       ?= armControllerTb
SEED      ?= 1
OBJ_DIR   ?= obj_dir
FILELIST  ?= project.f
VFLAGS    ?= --binary --timing --assert

SOURCES := $(wildcard hw/*.sv dv/*.sv dv/*.svh)
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: compile run clean

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the testbench prints the pass line
run: $(BINARY)
	@out="$$(./$(BINARY) +verilator+seed+$(SEED))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/ctrlModel.svh
`ifndef CTRL_MODEL_SVH
`define CTRL_MODEL_SVH

// ==================================================
// Reference model of the control pipeline
// ==================================================

// Control bits as decoded in D, held in E
typedef struct packed {
  logic    regWrite;
  logic    memWrite;
  logic    memtoReg;
  logic    branch;
  logic    pcWrite;     // Not yet gated
  logic    aluSrc;
  aluCtrlT aluControl;
  logic    flagNz;
  logic    flagCv;
  logic    byteAccess;
  condT    cond;
  ImmSrcT  immSrc;
  RegSrcT  regSrc;
} decodeT;

// Condition-gated bits, held in M and W
typedef struct packed {
  logic     regWrite;
  logic     memWrite;
  logic     memtoReg;
  logic     pcWrite;    // Gated, becomes pcSrcW in W
  logic     setFlags;
  flagsT    flagsNext;
  byteMaskT byteMask;
} retireT;

decodeT mdlE;      // E-stage register
retireT mdlM;      // M-stage register
retireT mdlW;      // W-stage register
flagsT  mdlFlags;  // Architectural NZCV

function automatic decodeT expectedDecode(input instrT ins);
  decodeT  d;
  aluCtrlT op;
  logic    logicalOp;
  d  = '0;
  op = ins[24:21];
  d.cond = ins[31:28];                          // Carried for every class
  if (ins[27:26] == ClassDp) begin
    d.regWrite   = !(op inside {OpTst, OpTeq, OpCmp, OpCmn});  // Compare group writes no Rd
    d.aluSrc     = ins[25];
    d.aluControl = op;
    d.flagNz     = ins[20];
    // AND EOR ORR MOV BIC MVN TST TEQ keep C and V
    logicalOp = op inside {4'b0000, 4'b0001, 4'b1100, 4'b1101, 4'b1110, 4'b1111,
                           OpTst, OpTeq};
    d.flagCv     = ins[20] & ~logicalOp;
  end else if (ins[27:26] == ClassMem && !(ins[25] && ins[4])) begin
    // Register offset with bit 4 set is not a load or store
    d.regWrite   = ins[20];                     // L bit
    d.memWrite   = ~ins[20];
    d.memtoReg   = ins[20];
    d.aluSrc     = ~ins[25];                    // Immediate offset
    d.aluControl = ins[23] ? OpAdd : OpSub;     // U bit
    d.byteAccess = ins[22];
    d.immSrc     = 2'b01;
    d.regSrc     = ins[20] ? 2'b00 : 2'b10;     // Store data comes from Rd
  end else if (ins[27:26] == ClassBranch) begin
    d.branch     = 1'b1;
    d.aluSrc     = 1'b1;
    d.aluControl = OpAdd;
    d.immSrc     = 2'b10;
    d.regSrc     = 2'b01;
  end
  d.pcWrite = d.branch | (d.regWrite & (ins[15:12] == PcReg));
  return d;
endfunction

// Base test on code[3:1], odd codes invert it
function automatic logic conditionPasses(input condT c, input flagsT f);
  logic base;
  case (c[3:1])
    3'b000:  base = f[FlagZ];
    3'b001:  base = f[FlagC];
    3'b010:  base = f[FlagN];
    3'b011:  base = f[FlagV];
    3'b100:  base = f[FlagC] & ~f[FlagZ];
    3'b101:  base = (f[FlagN] == f[FlagV]);
    3'b110:  base = ~f[FlagZ] & (f[FlagN] == f[FlagV]);
    default: base = 1'b1;                       // AL, and 1111 inverts to never
  endcase
  return c[0] ? ~base : base;
endfunction

// Youngest unretired flag result
function automatic flagsT forwardedFlags();
  if (mdlM.setFlags)      return mdlM.flagsNext;
  else if (mdlW.setFlags) return mdlW.flagsNext;
  else                    return mdlFlags;
endfunction

// What E hands to M this cycle
function automatic retireT executeResult(input flagsT aluF, input logic [1:0] offset);
  retireT r;
  flagsT  fwd;
  logic   pass;
  fwd  = forwardedFlags();
  pass = conditionPasses(mdlE.cond, fwd);
  r.regWrite  = mdlE.regWrite & pass;
  r.memWrite  = mdlE.memWrite & pass;
  r.memtoReg  = mdlE.memtoReg;
  r.pcWrite   = mdlE.pcWrite & pass;
  r.setFlags  = (mdlE.flagNz | mdlE.flagCv) & pass;
  r.flagsNext = fwd;
  if (mdlE.flagNz) begin
    r.flagsNext[FlagN] = aluF[FlagN];
    r.flagsNext[FlagZ] = aluF[FlagZ];
  end
  if (mdlE.flagCv) begin
    r.flagsNext[FlagC] = aluF[FlagC];
    r.flagsNext[FlagV] = aluF[FlagV];
  end
  if (!r.memWrite)          r.byteMask = 4'b0000;
  else if (mdlE.byteAccess) r.byteMask = 4'b0001 << offset;  // One lane
  else                      r.byteMask = 4'b1111;
  return r;
endfunction

// One rising edge, reads the testbench's input signals
task automatic stepModel();
  retireT eOut;
  if (reset) begin
    mdlE     = '0;
    mdlM     = '0;
    mdlW     = '0;
    mdlFlags = '0;
  end else begin
    eOut = executeResult(aluFlagsE, byteOffsetE);
    if (!stallW && mdlW.setFlags) mdlFlags = mdlW.flagsNext;  // Retire ignores flushW
    if (flushW)       mdlW = '0;
    else if (!stallW) mdlW = mdlM;
    if (flushM)       mdlM = '0;
    else if (!stallM) mdlM = eOut;
    if (flushE)       mdlE = '0;
    else if (!stallE) mdlE = expectedDecode(instrD);
  end
endtask

`endif

// File: dv/armControllerTb.sv
`timescale 1ns/100ps

module armControllerTb import ctrlPkg::*; ();

  localparam bit [31:0] Seed = 32'ha8d2_0c92;
  localparam int ClkPeriod    = 100;
  localparam int ResetCycles  = 2;
  localparam int DecodeCycles = 400;
  localparam int CondCycles   = 400;
  localparam int FlagCycles   = 300;
  localparam int ByteCycles   = 200;
  localparam int StallCycles  = 500;
  localparam int MarginCycles = 50;
  localparam int TotalCycles  = ResetCycles + DecodeCycles + CondCycles + FlagCycles
                                + ByteCycles + StallCycles;

  // Stimulus mixes
  localparam int ModeDecode = 0;
  localparam int ModeCond   = 1;
  localparam int ModeFlags  = 2;
  localparam int ModeBytes  = 3;
  localparam int ModeStall  = 4;

  logic       clk;
  logic       reset;
  instrT      instrD;
  flagsT      aluFlagsE;
  logic [1:0] byteOffsetE;
  logic       stallE;
  logic       flushE;
  logic       stallM;
  logic       flushM;
  logic       stallW;
  logic       flushW;
  ImmSrcT     immSrcD;
  RegSrcT     regSrcD;
  aluCtrlT    aluControlE;
  logic       aluSrcE;
  logic       branchTakenE;
  flagsT      flagsE;
  logic       memWriteM;
  byteMaskT   byteMaskM;
  logic       regWriteW;
  logic       memtoRegW;
  logic       pcSrcW;
  logic       pcWrPendingF;

  int testCount  = 0;
  int checkCount = 0;
  int errorCount = 0;

  `include "ctrlModel.svh"

  armController u_dut (
    .clk          (clk),
    .reset        (reset),
    .instrD       (instrD),
    .immSrcD      (immSrcD),
    .regSrcD      (regSrcD),
    .aluFlagsE    (aluFlagsE),
    .byteOffsetE  (byteOffsetE),
    .aluControlE  (aluControlE),
    .aluSrcE      (aluSrcE),
    .branchTakenE (branchTakenE),
    .flagsE       (flagsE),
    .memWriteM    (memWriteM),
    .byteMaskM    (byteMaskM),
    .regWriteW    (regWriteW),
    .memtoRegW    (memtoRegW),
    .pcSrcW       (pcSrcW),
    .stallE       (stallE),
    .flushE       (flushE),
    .stallM       (stallM),
    .flushM       (flushM),
    .stallW       (stallW),
    .flushW       (flushW),
    .pcWrPendingF (pcWrPendingF)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // ==================================================
  // Checking
  // ==================================================
  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("[FAIL] %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // Sampled at the falling edge before new inputs go out
  task automatic checkOutputs();
    decodeT d;
    flagsT  fwd;
    d   = expectedDecode(instrD);
    fwd = forwardedFlags();
    compare("immSrcD", 32'(immSrcD), 32'(d.immSrc));      // Same cycle as instrD
    compare("regSrcD", 32'(regSrcD), 32'(d.regSrc));
    compare("aluControlE", 32'(aluControlE), 32'(mdlE.aluControl));
    compare("aluSrcE", 32'(aluSrcE), 32'(mdlE.aluSrc));
    compare("branchTakenE", 32'(branchTakenE),
            32'(mdlE.branch & conditionPasses(mdlE.cond, fwd)));
    compare("flagsE", 32'(flagsE), 32'(fwd));
    compare("memWriteM", 32'(memWriteM), 32'(mdlM.memWrite));
    compare("byteMaskM", 32'(byteMaskM), 32'(mdlM.byteMask));
    compare("regWriteW", 32'(regWriteW), 32'(mdlW.regWrite));
    compare("memtoRegW", 32'(memtoRegW), 32'(mdlW.memtoReg));
    compare("pcSrcW", 32'(pcSrcW), 32'(mdlW.pcWrite));
    compare("pcWrPendingF", 32'(pcWrPendingF),
            32'(d.pcWrite | mdlE.pcWrite | mdlM.pcWrite));
  endtask

  // ==================================================
  // Stimulus
  // ==================================================
  function automatic instrT makeInstr(input int unsigned dpW, input int unsigned memW,
                                      input int unsigned brW, input bit randCond,
                                      input bit setS);
    instrT       w;
    int unsigned pick;
    w    = $urandom();
    pick = $urandom_range(99);
    if (pick < dpW)                    w[27:26] = ClassDp;
    else if (pick < dpW + memW)        w[27:26] = ClassMem;
    else if (pick < dpW + memW + brW) begin
      w[27:26] = ClassBranch;
      w[25]    = 1'b1;                               // B / BL
    end else                           w[27:26] = 2'b11;  // Decodes as a bubble
    if ($urandom_range(7) == 0) w[15:12] = PcReg;    // Some R15 destinations
    if (!randCond || $urandom_range(3) == 0) w[31:28] = CondAl;
    if (setS && w[27:26] == ClassDp) w[20] = 1'b1;
    return w;
  endfunction

  task automatic driveInputs(input int mode);
    instrT       next;
    int unsigned lvl;
    case (mode)
      ModeDecode: next = makeInstr(40, 30, 20, 1'b0, 1'b0);
      ModeFlags:  next = makeInstr(80, 0, 20, 1'b1, 1'b1);   // Dependent S-bit chains
      ModeBytes: begin
        next    = makeInstr(0, 100, 0, 1'b0, 1'b0);
        next[4] = 1'b0;                                      // Keep it a real LDR/STR
      end
      default:    next = makeInstr(40, 30, 20, 1'b1, 1'b0);
    endcase
    aluFlagsE   = 4'($urandom());
    byteOffsetE = 2'($urandom());
    stallE = 1'b0;
    flushE = 1'b0;
    stallM = 1'b0;
    flushM = 1'b0;
    stallW = 1'b0;                                           // W never stalls here
    flushW = 1'b0;
    if (mode == ModeStall) begin
      lvl = $urandom_range(5);
      if (lvl == 1) begin          // D and E hold while M takes a bubble
        stallE = 1'b1;
        flushM = 1'b1;
      end else if (lvl == 2) begin // D, E and M hold while W takes a bubble
        stallE = 1'b1;
        stallM = 1'b1;
        flushW = 1'b1;
      end else if (lvl == 3) begin
        flushE = 1'b1;
      end else if (lvl == 4) begin
        flushM = 1'($urandom());
        flushW = 1'($urandom());
      end
    end
    if (!stallE) instrD = next;    // D holds along with E
  endtask

  task automatic tick();
    @(posedge clk);
    stepModel();
    @(negedge clk);
  endtask

  task automatic runTest(input string name, input int mode, input int cycles);
    int i;
    int checksBefore;
    int errorsBefore;
    checksBefore = checkCount;
    errorsBefore = errorCount;
    for (i = 0; i < cycles; i++) begin
      driveInputs(mode);
      tick();
      checkOutputs();
    end
    testCount++;
    $display("test %-10s %4d cycles, %5d checks, %0d mismatches", name, cycles,
             checkCount - checksBefore, errorCount - errorsBefore);
  endtask

  // All control outputs quiet straight out of reset
  task automatic checkResetState();
    int errorsBefore;
    errorsBefore = errorCount;
    compare("regWriteW after reset", 32'(regWriteW), 32'd0);
    compare("memWriteM after reset", 32'(memWriteM), 32'd0);
    compare("pcSrcW after reset", 32'(pcSrcW), 32'd0);
    compare("branchTakenE after reset", 32'(branchTakenE), 32'd0);
    compare("pcWrPendingF after reset", 32'(pcWrPendingF), 32'd0);
    compare("byteMaskM after reset", 32'(byteMaskM), 32'd0);
    compare("flagsE after reset", 32'(flagsE), 32'd0);
    checkOutputs();
    testCount++;
    $display("test %-10s %4d cycles, %0d mismatches", "reset", ResetCycles,
             errorCount - errorsBefore);
  endtask

  // ==================================================
  // Main sequence
  // ==================================================
  initial begin
    void'($urandom(Seed));
    reset       = 1'b1;
    instrD      = '0;
    aluFlagsE   = '0;
    byteOffsetE = '0;
    stallE      = 1'b0;
    flushE      = 1'b0;
    stallM      = 1'b0;
    flushM      = 1'b0;
    stallW      = 1'b0;
    flushW      = 1'b0;
    repeat (ResetCycles) tick();
    reset = 1'b0;                  // Released on a falling edge
    checkResetState();
    runTest("decode", ModeDecode, DecodeCycles);
    runTest("condition", ModeCond, CondCycles);
    runTest("flags", ModeFlags, FlagCycles);
    runTest("byteLanes", ModeBytes, ByteCycles);
    runTest("stallFlush", ModeStall, StallCycles);
    $display("Summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Watchdog sized from the test lengths
  initial begin
    #((TotalCycles + MarginCycles) * ClkPeriod);
    $display("Timeout: the run did not finish within %0d clock cycles",
             TotalCycles + MarginCycles);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// File: hw/armController.sv
`timescale 1ns/100ps

module armController import ctrlPkg::*; (
  input  logic       clk,
  input  logic       reset,
  // Decode
  input  instrT      instrD,
  output ImmSrcT     immSrcD,
  output RegSrcT     regSrcD,
  // Execute
  input  flagsT      aluFlagsE,
  input  logic [1:0] byteOffsetE,
  output aluCtrlT    aluControlE,
  output logic       aluSrcE,
  output logic       branchTakenE,
  output flagsT      flagsE,
  // Memory
  output logic       memWriteM,
  output byteMaskT   byteMaskM,
  // Writeback
  output logic       regWriteW,
  output logic       memtoRegW,
  output logic       pcSrcW,
  // Hazard unit
  input  logic       stallE,
  input  logic       flushE,
  input  logic       stallM,
  input  logic       flushM,
  input  logic       stallW,
  input  logic       flushW,
  output logic       pcWrPendingF
);

  logic pcWriteE;
  logic pcWriteM;

  ctrlStageIf decodeBus ();
  memStageIf  memBus ();

  instrDecoder decodeUnit (
    .instrD    (instrD),
    .decodeBus (decodeBus.decoder),
    .immSrcD   (immSrcD),
    .regSrcD   (regSrcD)
  );

  executeCtrl executeUnit (
    .clk          (clk),
    .reset        (reset),
    .stallE       (stallE),
    .flushE       (flushE),
    .decodeBus    (decodeBus.execute),
    .flagsE       (flagsE),            // Loops back from retire
    .aluFlagsE    (aluFlagsE),
    .byteOffsetE  (byteOffsetE),
    .aluControlE  (aluControlE),
    .aluSrcE      (aluSrcE),
    .branchTakenE (branchTakenE),
    .pcWriteE     (pcWriteE),
    .memBus       (memBus.execute)
  );

  writebackCtrl retireUnit (
    .clk       (clk),
    .reset     (reset),
    .stallM    (stallM),
    .flushM    (flushM),
    .stallW    (stallW),
    .flushW    (flushW),
    .memBus    (memBus.retire),
    .memWriteM (memWriteM),
    .byteMaskM (byteMaskM),
    .pcWriteM  (pcWriteM),
    .regWriteW (regWriteW),
    .memtoRegW (memtoRegW),
    .pcSrcW    (pcSrcW),
    .flagsE    (flagsE)
  );

  // Fetch holds while any PC write is still in flight
  assign pcWrPendingF = decodeBus.pcWrite | pcWriteE | pcWriteM;

endmodule

// File: hw/writebackCtrl.sv
`timescale 1ns/100ps

module writebackCtrl import ctrlPkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        stallM,
  input  logic        flushM,
  input  logic        stallW,
  input  logic        flushW,
  memStageIf.retire   memBus,
  output logic        memWriteM,
  output byteMaskT    byteMaskM,
  output logic        pcWriteM,
  output logic        regWriteW,
  output logic        memtoRegW,
  output logic        pcSrcW,
  output flagsT       flagsE
);

  logic  regWriteM;
  logic  memtoRegM;
  logic  setFlagsM;
  flagsT flagsNextM;
  logic  setFlagsW;
  flagsT flagsNextW;
  flagsT flagsReg;     // Architectural NZCV

  // ==================================================
  // M-stage register
  // ==================================================
  always_ff @(posedge clk) begin
    if (reset || flushM) begin
      regWriteM  <= 1'b0;
      memWriteM  <= 1'b0;
      memtoRegM  <= 1'b0;
      pcWriteM   <= 1'b0;
      setFlagsM  <= 1'b0;
      flagsNextM <= '0;
      byteMaskM  <= '0;
    end else if (!stallM) begin
      regWriteM  <= memBus.regWrite;
      memWriteM  <= memBus.memWrite;
      memtoRegM  <= memBus.memtoReg;
      pcWriteM   <= memBus.pcWrite;
      setFlagsM  <= memBus.setFlags;
      flagsNextM <= memBus.flagsNext;
      byteMaskM  <= memBus.byteMask;
    end
  end

  // ==================================================
  // W-stage register
  // ==================================================
  always_ff @(posedge clk) begin
    if (reset || flushW) begin
      regWriteW  <= 1'b0;
      memtoRegW  <= 1'b0;
      pcSrcW     <= 1'b0;
      setFlagsW  <= 1'b0;
      flagsNextW <= '0;
    end else if (!stallW) begin
      regWriteW  <= regWriteM;
      memtoRegW  <= memtoRegM;
      pcSrcW     <= pcWriteM;
      setFlagsW  <= setFlagsM;
      flagsNextW <= flagsNextM;
    end
  end

  // Flags retire at the edge that ends W
  always_ff @(posedge clk) begin
    if (reset)                        flagsReg <= '0;
    else if (!stallW && setFlagsW)    flagsReg <= flagsNextW;
  end

  // Youngest pending flag result wins
  assign flagsE = setFlagsM ? flagsNextM :
                  setFlagsW ? flagsNextW : flagsReg;

  // Reset leaves nothing retiring into the register file
  wbQuietAfterReset: assert property (@(posedge clk)
    reset |=> (!regWriteW && !memtoRegW && flagsReg == '0))
    else $error("writeback active after reset");

endmodule

// File: hw/executeCtrl.sv
`timescale 1ns/100ps

module executeCtrl import ctrlPkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         stallE,
  input  logic         flushE,
  ctrlStageIf.execute  decodeBus,
  input  flagsT        flagsE,        // Forwarded from the retire side
  input  flagsT        aluFlagsE,
  input  logic [1:0]   byteOffsetE,   // Address bits 1:0 from the ALU
  output aluCtrlT      aluControlE,
  output logic         aluSrcE,
  output logic         branchTakenE,
  output logic         pcWriteE,
  memStageIf.execute   memBus
);

  logic  regWriteE;
  logic  memWriteE;
  logic  memtoRegE;
  logic  branchE;
  logic  flagWriteNzE;
  logic  flagWriteCvE;
  logic  byteAccessE;
  condT  condE;
  logic  condExE;
  logic  memWriteGatedE;

  // ==================================================
  // E-stage register
  // ==================================================
  always_ff @(posedge clk) begin
    if (reset || flushE) begin            // Flush wins over stall
      regWriteE    <= 1'b0;
      memWriteE    <= 1'b0;
      memtoRegE    <= 1'b0;
      branchE      <= 1'b0;
      pcWriteE     <= 1'b0;
      aluSrcE      <= 1'b0;
      aluControlE  <= '0;
      flagWriteNzE <= 1'b0;
      flagWriteCvE <= 1'b0;
      byteAccessE  <= 1'b0;
      condE        <= '0;
    end else if (!stallE) begin
      regWriteE    <= decodeBus.regWrite;
      memWriteE    <= decodeBus.memWrite;
      memtoRegE    <= decodeBus.memtoReg;
      branchE      <= decodeBus.branch;
      pcWriteE     <= decodeBus.pcWrite;
      aluSrcE      <= decodeBus.aluSrc;
      aluControlE  <= decodeBus.aluControl;
      flagWriteNzE <= decodeBus.flagWriteNz;
      flagWriteCvE <= decodeBus.flagWriteCv;
      byteAccessE  <= decodeBus.byteAccess;
      condE        <= decodeBus.cond;
    end
  end

  condUnit condCheck (
    .cond        (condE),
    .flags       (flagsE),
    .aluFlags    (aluFlagsE),
    .flagWriteNz (flagWriteNzE),
    .flagWriteCv (flagWriteCvE),
    .condEx      (condExE),
    .flagsNext   (memBus.flagsNext)
  );

  // Everything architectural is gated by the condition
  assign branchTakenE    = branchE & condExE;
  assign memWriteGatedE  = memWriteE & condExE;
  assign memBus.regWrite = regWriteE & condExE;
  assign memBus.memWrite = memWriteGatedE;
  assign memBus.memtoReg = memtoRegE;
  assign memBus.pcWrite  = pcWriteE & condExE;
  assign memBus.setFlags = (flagWriteNzE | flagWriteCvE) & condExE;

  // Store lanes
  always_comb begin
    if (!memWriteGatedE)  memBus.byteMask = '0;       // Loads, DP, failed cond
    else if (byteAccessE) memBus.byteMask = 4'b0001 << byteOffsetE;
    else                  memBus.byteMask = '1;       // Word store
  end

  // A lane enable never leaves E without the gated store behind it
  maskNeedsStore: assert property (@(posedge clk) disable iff (reset)
    (memBus.byteMask != '0) |-> (memBus.memWrite && condExE))
    else $error("byteMask set without a store");

endmodule

// File: hw/instrDecoder.sv
`timescale 1ns/100ps

module instrDecoder import ctrlPkg::*; (
  input  instrT              instrD,
  ctrlStageIf.decoder        decodeBus,
  output ImmSrcT             immSrcD,
  output RegSrcT             regSrcD
);

  logic [1:0] opClass;
  aluCtrlT    dpOp;
  logic       sBit;
  logic       isLoad;
  logic       upBit;
  logic       regOffset;
  logic       rdIsPc;
  logic       isCompare;
  logic       isArith;
  logic       memUndef;

  // ==================================================
  // Instruction fields
  // ==================================================
  assign opClass   = instrD[27:26];
  assign dpOp      = instrD[24:21];
  assign sBit      = instrD[20];
  assign isLoad    = instrD[20];                 // L bit, same position as S
  assign upBit     = instrD[23];                 // U bit, add or subtract offset
  assign regOffset = instrD[25];                 // Memory: I bit set means register offset
  assign rdIsPc    = (instrD[15:12] == PcReg);
  assign memUndef  = regOffset & instrD[4];      // Undefined space inside LDR/STR

  // Compare/test write flags only
  assign isCompare = dpOp inside {OpTst, OpTeq, OpCmp, OpCmn};
  // Logical ops leave C and V alone
  assign isArith   = dpOp inside {OpSub, OpRsb, OpAdd, OpAdc, OpSbc, OpRsc, OpCmp, OpCmn};

  assign decodeBus.cond = instrD[31:28];

  always_comb begin
    // Bubble by default, covers coprocessor, SWI and undefined encodings
    decodeBus.regWrite    = 1'b0;
    decodeBus.memWrite    = 1'b0;
    decodeBus.memtoReg    = 1'b0;
    decodeBus.branch      = 1'b0;
    decodeBus.aluSrc      = 1'b0;
    decodeBus.aluControl  = '0;
    decodeBus.flagWriteNz = 1'b0;
    decodeBus.flagWriteCv = 1'b0;
    decodeBus.byteAccess  = 1'b0;
    immSrcD               = 2'b00;
    regSrcD               = 2'b00;
    case (opClass)
      ClassDp: begin
        decodeBus.regWrite    = ~isCompare;
        decodeBus.aluSrc      = instrD[25];      // Rotated imm8 form
        decodeBus.aluControl  = dpOp;
        decodeBus.flagWriteNz = sBit;
        decodeBus.flagWriteCv = sBit & isArith;
      end
      ClassMem: begin
        if (!memUndef) begin
          decodeBus.regWrite   = isLoad;
          decodeBus.memWrite   = ~isLoad;
          decodeBus.memtoReg   = isLoad;
          decodeBus.aluSrc     = ~regOffset;     // imm12 offset
          decodeBus.aluControl = upBit ? OpAdd : OpSub;
          decodeBus.byteAccess = instrD[22];     // B bit
          immSrcD              = 2'b01;          // imm12
          regSrcD              = isLoad ? 2'b00 : 2'b10;  // Stores read Rd as data
        end
      end
      ClassBranch: begin
        decodeBus.branch     = 1'b1;
        decodeBus.aluSrc     = 1'b1;
        decodeBus.aluControl = OpAdd;            // PC + offset
        immSrcD              = 2'b10;            // imm24 << 2
        regSrcD              = 2'b01;            // Read R15
      end
      default: ;
    endcase
    // Any write to R15 redirects fetch
    decodeBus.pcWrite = (decodeBus.regWrite & rdIsPc) | decodeBus.branch;
  end

  // Flag writes come from DP only, never from memory or branch decode
  always_comb begin
    if (decodeBus.flagWriteNz || decodeBus.flagWriteCv) begin
      assert (instrD[27:26] == ClassDp && decodeBus.flagWriteNz)
        else $error("flag write decoded outside data processing");
    end
  end

endmodule

// File: hw/condUnit.sv
`timescale 1ns/100ps

module condUnit import ctrlPkg::*; (
  input  condT  cond,
  input  flagsT flags,        // Forwarded NZCV seen by this instruction
  input  flagsT aluFlags,     // NZCV produced by the ALU this cycle
  input  logic  flagWriteNz,
  input  logic  flagWriteCv,
  output logic  condEx,
  output flagsT flagsNext
);

  logic n;
  logic z;
  logic c;
  logic v;

  assign n = flags[FlagN];
  assign z = flags[FlagZ];
  assign c = flags[FlagC];
  assign v = flags[FlagV];

  // ==================================================
  // Condition table
  // ==================================================
  always_comb begin
    case (cond)
      CondEq:  condEx = z;
      CondNe:  condEx = ~z;
      CondCs:  condEx = c;
      CondCc:  condEx = ~c;
      CondMi:  condEx = n;
      CondPl:  condEx = ~n;
      CondVs:  condEx = v;
      CondVc:  condEx = ~v;
      CondHi:  condEx = c & ~z;           // Unsigned higher
      CondLs:  condEx = ~c | z;
      CondGe:  condEx = (n == v);         // Signed compare
      CondLt:  condEx = (n != v);
      CondGt:  condEx = ~z & (n == v);
      CondLe:  condEx = z | (n != v);
      CondAl:  condEx = 1'b1;
      default: condEx = 1'b0;             // 1111 never executes here
    endcase
  end

  // Next flags, per group
  always_comb begin
    flagsNext = flags;
    if (flagWriteNz) begin
      flagsNext[FlagN] = aluFlags[FlagN];
      flagsNext[FlagZ] = aluFlags[FlagZ];
    end
    if (flagWriteCv) begin
      flagsNext[FlagC] = aluFlags[FlagC];
      flagsNext[FlagV] = aluFlags[FlagV];
    end
  end

endmodule

// File: hw/stageIfs.sv
`timescale 1ns/100ps

// Decode bundle, decoder -> execute stage register
interface ctrlStageIf import ctrlPkg::*; ();
  logic    regWrite;
  logic    memWrite;
  logic    memtoReg;     // Result from memory, loads only
  logic    branch;
  logic    pcWrite;      // Branch or write to R15
  logic    aluSrc;       // Second operand is the immediate
  aluCtrlT aluControl;
  logic    flagWriteNz;
  logic    flagWriteCv;  // Arithmetic ops only
  logic    byteAccess;   // LDRB / STRB
  condT    cond;

  modport decoder (output regWrite, memWrite, memtoReg, branch, pcWrite, aluSrc,
                   aluControl, flagWriteNz, flagWriteCv, byteAccess, cond);
  modport execute (input  regWrite, memWrite, memtoReg, branch, pcWrite, aluSrc,
                   aluControl, flagWriteNz, flagWriteCv, byteAccess, cond);
endinterface

// Condition-gated bundle, execute -> memory/writeback
interface memStageIf import ctrlPkg::*; ();
  logic     regWrite;   // Already gated by the condition
  logic     memWrite;   // Gated
  logic     memtoReg;
  logic     pcWrite;    // Gated
  logic     setFlags;   // Retire writes flagsNext to NZCV
  flagsT    flagsNext;
  byteMaskT byteMask;   // Zero unless a store goes out

  modport execute (output regWrite, memWrite, memtoReg, pcWrite,
                   setFlags, flagsNext, byteMask);
  modport retire  (input  regWrite, memWrite, memtoReg, pcWrite,
                   setFlags, flagsNext, byteMask);
endinterface

// File: hw/ctrlPkg.sv
package ctrlPkg;

  // ==================================================
  // Field types
  // ==================================================
  typedef logic [31:0] instrT;     // Raw instruction word
  typedef logic [3:0]  flagsT;     // NZCV, N in bit 3
  typedef logic [3:0]  condT;      // Condition field, instr[31:28]
  typedef logic [3:0]  aluCtrlT;   // DP opcode, instr[24:21]
  typedef logic [3:0]  byteMaskT;  // Store lane enables
  typedef logic [1:0]  ImmSrcT;    // Immediate extender format
  typedef logic [1:0]  RegSrcT;    // Register file read select

  // ALU opcodes, ARM data-processing encoding
  localparam aluCtrlT OpSub = 4'b0010;
  localparam aluCtrlT OpRsb = 4'b0011;
  localparam aluCtrlT OpAdd = 4'b0100;
  localparam aluCtrlT OpAdc = 4'b0101;
  localparam aluCtrlT OpSbc = 4'b0110;
  localparam aluCtrlT OpRsc = 4'b0111;
  localparam aluCtrlT OpTst = 4'b1000;
  localparam aluCtrlT OpTeq = 4'b1001;
  localparam aluCtrlT OpCmp = 4'b1010;
  localparam aluCtrlT OpCmn = 4'b1011;
  localparam aluCtrlT OpMov = 4'b1101;

  // Condition codes, 4'b1111 is never
  localparam condT CondEq = 4'b0000;
  localparam condT CondNe = 4'b0001;
  localparam condT CondCs = 4'b0010;
  localparam condT CondCc = 4'b0011;
  localparam condT CondMi = 4'b0100;
  localparam condT CondPl = 4'b0101;
  localparam condT CondVs = 4'b0110;
  localparam condT CondVc = 4'b0111;
  localparam condT CondHi = 4'b1000;
  localparam condT CondLs = 4'b1001;
  localparam condT CondGe = 4'b1010;
  localparam condT CondLt = 4'b1011;
  localparam condT CondGt = 4'b1100;
  localparam condT CondLe = 4'b1101;
  localparam condT CondAl = 4'b1110;

  // Bit positions inside flagsT
  localparam int FlagN = 3;
  localparam int FlagZ = 2;
  localparam int FlagC = 1;
  localparam int FlagV = 0;

  // Instruction class, instr[27:26]
  localparam logic [1:0] ClassDp     = 2'b00;
  localparam logic [1:0] ClassMem    = 2'b01;
  localparam logic [1:0] ClassBranch = 2'b10;

  localparam logic [3:0] PcReg = 4'd15;  // R15 as destination means a PC write

endpackage
